//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_router_in_port
FILELIST = all.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "\*\* PASS \*\*" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
logic/noc_pkg.sv
logic/flit_if.sv
logic/xy_route_calc.sv
logic/flit_buffer.sv
logic/packet_counter.sv
logic/wormhole_fsm.sv
logic/router_in_port.sv
verif/route_checker.sv
verif/tb_router_in_port.sv

//--- logic/flit_buffer.sv
`timescale 1ns/10ps

// two entry circular fifo
// write side from the input handshake, read side on a flit link
module flit_buffer (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       wr_en,
   input  logic [noc_pkg::flit_w-1:0] wr_flit,
   output logic                       full,
   flit_if.sender                     rd
);

   // entry storage
   logic [noc_pkg::flit_w-1:0] mem [2];

   logic       wr_ptr;
   logic       rd_ptr;
   // 0, 1 or 2 entries
   logic [1:0] count;
   logic       pop;

   assign pop  = rd.ack;
   assign full = (count == 2'd2);

   // front entry and not-empty flag
   assign rd.req  = (count != 2'd0);
   assign rd.flit = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_flit;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count  <= 2'd0;
      end else begin
         if (wr_en) begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop) begin
            rd_ptr <= ~rd_ptr;
         end
         // count only moves when one side acts alone
         case ({wr_en, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;
         endcase
      end
   end

   // input control must respect full, fsm must respect empty
   a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));
   a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) !(pop && !rd.req));

endmodule

//--- logic/flit_if.sv
`timescale 1ns/10ps

// flit link between two blocks
// at the chip ports this is a four-phase req/ack pair
// inside the port, req is a ready flag and ack a single-cycle pop
interface flit_if;

   // request or not-empty
   logic req;
   // acknowledge or pop
   logic ack;
   // data word, stable while req is high
   logic [noc_pkg::flit_w-1:0] flit;

   // side that offers flits
   modport sender (
      output req,
      output flit,
      input  ack
   );

   // side that takes flits
   modport receiver (
      input  req,
      input  flit,
      output ack
   );

endinterface

//--- logic/noc_pkg.sv
package noc_pkg;

   ////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////

   // one flit is one 16 bit word
   localparam int flit_w = 16;
   // x and y fields of the head flit
   localparam int coord_w = 4;
   // body length field, 0 to 15 body flits
   localparam int len_w = 4;
   // local, east, west, south, north
   localparam int num_ports = 5;

   ////////////////////////////////////////////////
   // output one-hot positions
   ////////////////////////////////////////////////

   localparam int port_local = 0;
   localparam int port_east  = 1;
   localparam int port_west  = 2;
   // y increasing goes south
   localparam int port_south = 3;
   localparam int port_north = 4;

   ////////////////////////////////////////////////
   // head flit fields
   ////////////////////////////////////////////////

   // destination x in bits 3..0
   localparam int dx_lsb = 0;
   // destination y in bits 7..4
   localparam int dy_lsb = 4;
   // body length in bits 11..8, bits 15..12 free payload
   localparam int len_lsb = 8;

   // wormhole fsm states, also traced by the testbench
   typedef enum logic [2:0] {
      idle,
      route,
      send,
      wait_ack_hi,
      wait_ack_lo,
      drop
   } fsm_state_t;

endpackage

//--- logic/packet_counter.sv
`timescale 1ns/10ps

// body flits still to go in the current packet
module packet_counter (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      load,
   input  logic [noc_pkg::len_w-1:0] len,
   input  logic                      step,
   output logic                      last,
   output logic [noc_pkg::len_w-1:0] remaining
);

   // zero left, the flit just done closes the packet
   assign last = (remaining == '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remaining <= '0;
      end else if (load) begin
         // length field of the head flit
         remaining <= len;
      end else if (step) begin
         remaining <= remaining - 1'b1;
      end
   end

   // the fsm gates step with last, so the count never wraps
   a_no_wrap : assert property (@(posedge clk) disable iff (!rst_n) step |-> (remaining != '0));

endmodule

//--- logic/router_in_port.sv
`timescale 1ns/10ps

// one input port of a wormhole mesh router
module router_in_port #(
   parameter int node_x = 0,
   parameter int node_y = 1,
   parameter int mesh_x = 4,
   parameter int mesh_y = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          in_req,
   output logic                          in_ack,
   input  logic [noc_pkg::flit_w-1:0]    in_flit,
   output logic [noc_pkg::num_ports-1:0] out_req,
   input  logic [noc_pkg::num_ports-1:0] out_ack,
   output logic [noc_pkg::flit_w-1:0]    out_flit
);

   // buffer front to fsm, ready and pop
   flit_if link ();

   logic                          req_sync;
   logic                          wr_en;
   logic                          full;
   logic [2*noc_pkg::coord_w-1:0] dest;
   logic [noc_pkg::num_ports-1:0] port_sel;
   logic                          off_mesh;
   logic                          cnt_load;
   logic                          cnt_step;
   logic                          cnt_last;
   logic [noc_pkg::len_w-1:0]     remaining;

   ////////////////////////////////////////////////
   // input four-phase control
   ////////////////////////////////////////////////

   // new request, ack still low, room in the buffer
   assign wr_en = req_sync && !in_ack && !full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_sync <= 1'b0;
         in_ack   <= 1'b0;
      end else begin
         req_sync <= in_req;
         // set with the write, clear once req is seen low
         if (wr_en) begin
            in_ack <= 1'b1;
         end else if (!req_sync) begin
            in_ack <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////
   // datapath blocks
   ////////////////////////////////////////////////

   flit_buffer i_flit_buffer (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_flit (in_flit),
      .full    (full),
      .rd      (link.sender)
   );

   xy_route_calc #(
      .node_x (node_x),
      .node_y (node_y),
      .mesh_x (mesh_x),
      .mesh_y (mesh_y)
   ) i_xy_route_calc (
      .dest     (dest),
      .port_sel (port_sel),
      .off_mesh (off_mesh)
   );

   // length taken from the head at the buffer front
   packet_counter i_packet_counter (
      .clk       (clk),
      .rst_n     (rst_n),
      .load      (cnt_load),
      .len       (link.flit[noc_pkg::len_lsb +: noc_pkg::len_w]),
      .step      (cnt_step),
      .last      (cnt_last),
      .remaining (remaining)
   );

   wormhole_fsm i_wormhole_fsm (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd       (link.receiver),
      .port_sel (port_sel),
      .off_mesh (off_mesh),
      .cnt_load (cnt_load),
      .cnt_step (cnt_step),
      .cnt_last (cnt_last),
      .out_req  (out_req),
      .out_ack  (out_ack),
      .out_flit (out_flit),
      .dest     (dest)
   );

   // a dropped or delivered packet leaves the counter at zero
   a_idle_count : assert property (@(posedge clk) disable iff (!rst_n)
      (i_wormhole_fsm.state == noc_pkg::idle) |-> (remaining == '0));

endmodule

//--- logic/wormhole_fsm.sv
`timescale 1ns/10ps

// holds the route of one packet and runs the output handshakes
module wormhole_fsm (
   input  logic                          clk,
   input  logic                          rst_n,
   flit_if.receiver                      rd,
   input  logic [noc_pkg::num_ports-1:0] port_sel,
   input  logic                          off_mesh,
   output logic                          cnt_load,
   output logic                          cnt_step,
   input  logic                          cnt_last,
   output logic [noc_pkg::num_ports-1:0] out_req,
   input  logic [noc_pkg::num_ports-1:0] out_ack,
   output logic [noc_pkg::flit_w-1:0]    out_flit,
   output logic [2*noc_pkg::coord_w-1:0] dest
);

   noc_pkg::fsm_state_t state;

   // route of the head flit, kept for the body flits
   logic [noc_pkg::num_ports-1:0] port_q;
   // ack of the selected output only
   logic ack_hit;
   // next body flit can start
   logic launch;
   // off-mesh body flit can be dropped
   logic drop_pop;

   // head sits at the front while in route
   assign dest = rd.flit[2*noc_pkg::coord_w-1:0];

   assign ack_hit  = |(out_ack & port_q);
   assign launch   = (state == noc_pkg::wait_ack_lo) && !ack_hit && !cnt_last && rd.req;
   assign drop_pop = (state == noc_pkg::drop) && !cnt_last && rd.req;

   assign cnt_load = (state == noc_pkg::route);
   assign cnt_step = launch || drop_pop;

   ////////////////////////////////////////////////
   // buffer pop
   ////////////////////////////////////////////////

   // flit accepted, head of an off-mesh packet, or dropped body
   assign rd.ack = ((state == noc_pkg::route) && off_mesh) ||
                   (((state == noc_pkg::send) || (state == noc_pkg::wait_ack_hi)) && ack_hit) ||
                   drop_pop;

   ////////////////////////////////////////////////
   // state and output registers
   ////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= noc_pkg::idle;
         port_q   <= '0;
         out_req  <= '0;
         out_flit <= '0;
      end else begin
         case (state)
            noc_pkg::idle: begin
               // head flit at the front
               if (rd.req) begin
                  state <= noc_pkg::route;
               end
            end
            noc_pkg::route: begin
               port_q <= port_sel;
               if (off_mesh) begin
                  state <= noc_pkg::drop;
               end else begin
                  // offer the head
                  out_flit <= rd.flit;
                  out_req  <= port_sel;
                  state    <= noc_pkg::send;
               end
            end
            // first cycle of an offer, then keep waiting
            noc_pkg::send, noc_pkg::wait_ack_hi: begin
               if (ack_hit) begin
                  out_req <= '0;
                  state   <= noc_pkg::wait_ack_lo;
               end else begin
                  state <= noc_pkg::wait_ack_hi;
               end
            end
            noc_pkg::wait_ack_lo: begin
               // receiver done, packet over or next body flit
               if (!ack_hit && cnt_last) begin
                  state <= noc_pkg::idle;
               end else if (launch) begin
                  out_flit <= rd.flit;
                  out_req  <= port_q;
                  state    <= noc_pkg::send;
               end
            end
            noc_pkg::drop: begin
               // all body flits popped
               if (cnt_last) begin
                  state <= noc_pkg::idle;
               end
            end
            default: begin
               state <= noc_pkg::idle;
            end
         endcase
      end
   end

   // one output at a time, data held during the request
   a_req_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(out_req));
   a_flit_hold : assert property (@(posedge clk) disable iff (!rst_n)
      (|out_req) |=> $stable(out_flit));

endmodule

//--- logic/xy_route_calc.sv
`timescale 1ns/10ps

// dimension-order routing for one node of the mesh
// x is resolved first, then y
module xy_route_calc #(
   parameter int node_x = 0,
   parameter int node_y = 1,
   parameter int mesh_x = 4,
   parameter int mesh_y = 4
) (
   input  logic [2*noc_pkg::coord_w-1:0] dest,
   output logic [noc_pkg::num_ports-1:0] port_sel,
   output logic                          off_mesh
);

   // destination coordinates, zero extended for compare
   int dx;
   int dy;

   assign dx = int'(dest[noc_pkg::dx_lsb +: noc_pkg::coord_w]);
   assign dy = int'(dest[noc_pkg::dy_lsb +: noc_pkg::coord_w]);

   // either coordinate outside the mesh
   assign off_mesh = (dx >= mesh_x) || (dy >= mesh_y);

   ////////////////////////////////////////////////
   // port select
   ////////////////////////////////////////////////

   always_comb begin
      port_sel = '0;
      if (!off_mesh) begin
         // x first
         if (dx > node_x) begin
            port_sel[noc_pkg::port_east] = 1'b1;
         end else if (dx < node_x) begin
            port_sel[noc_pkg::port_west] = 1'b1;
         // x matches, then y
         end else if (dy > node_y) begin
            port_sel[noc_pkg::port_south] = 1'b1;
         end else if (dy < node_y) begin
            port_sel[noc_pkg::port_north] = 1'b1;
         end else begin
            // both match, deliver here
            port_sel[noc_pkg::port_local] = 1'b1;
         end
      end
   end

endmodule

//--- verif/route_checker.sv
`timescale 1ns/10ps

// watches the port pins of the router input port
// predicts each flit's output by the xy rule and compares at each out_req rise
module route_checker #(
   parameter int node_x = 0,
   parameter int node_y = 1,
   parameter int mesh_x = 4,
   parameter int mesh_y = 4
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          in_ack,
   input  logic [noc_pkg::flit_w-1:0]    in_flit,
   input  logic [noc_pkg::num_ports-1:0] exp_route,
   input  logic [noc_pkg::num_ports-1:0] out_req,
   input  logic [noc_pkg::flit_w-1:0]    out_flit,
   output int                            value_errors,
   output int                            other_errors,
   output int                            pending
);

   // expected output, port in the top bits, flit below
   logic [noc_pkg::num_ports+noc_pkg::flit_w-1:0] exp_q [$];

   int n_val = 0;
   int n_oth = 0;
   int n_pend = 0;

   // packet being received
   logic [noc_pkg::num_ports-1:0] port_now;
   logic in_packet = 1'b0;
   int   body_left = 0;
   // previous samples for edge detect
   logic ack_q = 1'b0;
   logic req_q = 1'b0;
   logic rst_q = 1'b0;

   assign value_errors = n_val;
   assign other_errors = n_oth;
   assign pending      = n_pend;

   // x first, then y, local when both match
   function automatic logic [noc_pkg::num_ports-1:0] xy_port(input int dx, input int dy);
      if (dx >= mesh_x || dy >= mesh_y) return '0;
      if (dx > node_x) return 5'b00001 << noc_pkg::port_east;
      if (dx < node_x) return 5'b00001 << noc_pkg::port_west;
      if (dy > node_y) return 5'b00001 << noc_pkg::port_south;
      if (dy < node_y) return 5'b00001 << noc_pkg::port_north;
      return 5'b00001 << noc_pkg::port_local;
   endfunction

   always @(posedge clk) begin
      logic [noc_pkg::num_ports+noc_pkg::flit_w-1:0] e;
      // first sample after release, before any flit is offered
      if (rst_n && !rst_q) begin
         if (in_ack !== 1'b0 || out_req !== '0 || out_flit !== '0) begin
            $display("[%0t] outputs not at their reset values after reset", $time);
            n_oth++;
         end
      end
      if (rst_n) begin
         // in_ack rise marks an accepted flit
         if (in_ack && !ack_q) begin
            if (!in_packet) begin
               port_now = xy_port(int'(in_flit[noc_pkg::dx_lsb +: noc_pkg::coord_w]),
                                  int'(in_flit[noc_pkg::dy_lsb +: noc_pkg::coord_w]));
               if (port_now !== exp_route) begin
                  $display("[%0t] xy rule gives %b but the table row says %b",
                           $time, port_now, exp_route);
                  n_oth++;
               end
               body_left = int'(in_flit[noc_pkg::len_lsb +: noc_pkg::len_w]);
               in_packet = (body_left != 0);
            end else begin
               body_left--;
               in_packet = (body_left != 0);
            end
            // off-mesh packets leave nothing to expect
            if (port_now != '0) begin
               exp_q.push_back({port_now, in_flit});
            end
         end
         // new offer on an output
         if (out_req != '0 && !req_q) begin
            if (exp_q.size() == 0) begin
               $display("[%0t] out_req raised with no flit left to deliver", $time);
               n_oth++;
            end else begin
               e = exp_q.pop_front();
               if (out_req !== e[noc_pkg::flit_w +: noc_pkg::num_ports]) begin
                  $display("[FAIL] t=%0t signal=out_req expected=%b actual=%b",
                           $time, e[noc_pkg::flit_w +: noc_pkg::num_ports], out_req);
                  n_val++;
               end
               if (out_flit !== e[noc_pkg::flit_w-1:0]) begin
                  $display("[FAIL] t=%0t signal=out_flit expected=%h actual=%h",
                           $time, e[noc_pkg::flit_w-1:0], out_flit);
                  n_val++;
               end
            end
         end
         if ($countones(out_req) > 1) begin
            $display("[%0t] more than one out_req bit is set: %b", $time, out_req);
            n_oth++;
         end
         ack_q = in_ack;
         req_q = |out_req;
      end
      rst_q = rst_n;
      n_pend = exp_q.size();
   end

endmodule

//--- verif/tb_router_in_port.sv
`timescale 1ns/10ps

module tb_router_in_port;

   localparam int node_x = 0;
   localparam int node_y = 1;
   localparam int mesh_x = 4;
   localparam int mesh_y = 4;
   localparam int num_pkts = 10;
   localparam int rand_seed = 32'h036c_c27b;

   typedef struct packed {
      logic [3:0]  dx;
      logic [3:0]  dy;
      logic [3:0]  len;
      logic [15:0] seed;
      logic [4:0]  port;
   } pkt_row_t;

   ////////////////////////////////////////////////
   // packet table
   ////////////////////////////////////////////////

   // dest x, dest y, body length, payload seed, expected one-hot port
   pkt_row_t pkt_tab [num_pkts] = '{
      '{4'd1, 4'd1, 4'd2,  16'h3a51, 5'b00010},
      '{4'd0, 4'd3, 4'd1,  16'hc4e2, 5'b01000},
      '{4'd0, 4'd0, 4'd0,  16'h7713, 5'b10000},
      '{4'd0, 4'd1, 4'd3,  16'h19b4, 5'b00001},
      // x first, leaves east not south
      '{4'd2, 4'd3, 4'd15, 16'h5ec5, 5'b00010},
      // off the mesh, dropped
      '{4'd4, 4'd1, 4'd2,  16'ha0f6, 5'b00000},
      '{4'd0, 4'd5, 4'd0,  16'h2d87, 5'b00000},
      '{4'd3, 4'd0, 4'd4,  16'hb618, 5'b00010},
      '{4'd0, 4'd2, 4'd15, 16'h8329, 5'b01000},
      '{4'd0, 4'd1, 4'd0,  16'hf03a, 5'b00001}
   };

   logic        clk;
   logic        rst_n;
   logic        in_req;
   logic        in_ack;
   logic [15:0] in_flit;
   logic [4:0]  out_req;
   wire  [4:0]  out_ack;
   logic [15:0] out_flit;
   logic [4:0]  exp_route;
   int          value_errors;
   int          other_errors;
   int          pending;
   int          cycles = 0;
   int          limit = 0;
   noc_pkg::fsm_state_t state_q = noc_pkg::idle;

   router_in_port #(
      .node_x (node_x), .node_y (node_y), .mesh_x (mesh_x), .mesh_y (mesh_y)
   ) i_router_in_port (
      .clk (clk), .rst_n (rst_n), .in_req (in_req), .in_ack (in_ack),
      .in_flit (in_flit), .out_req (out_req), .out_ack (out_ack), .out_flit (out_flit)
   );

   route_checker #(
      .node_x (node_x), .node_y (node_y), .mesh_x (mesh_x), .mesh_y (mesh_y)
   ) i_route_checker (
      .clk (clk), .rst_n (rst_n), .in_ack (in_ack), .in_flit (in_flit),
      .exp_route (exp_route), .out_req (out_req), .out_flit (out_flit),
      .value_errors (value_errors), .other_errors (other_errors), .pending (pending)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // one slow receiver per output, four-phase
   for (genvar p = 0; p < 5; p++) begin : g_rx
      logic ack;
      assign out_ack[p] = ack;
      initial begin
         int unsigned delay;
         ack = 1'b0;
         forever begin
            @(negedge clk);
            if (out_req[p]) begin
               delay = $urandom_range(5, 0);
               repeat (delay) @(negedge clk);
               ack = 1'b1;
               while (out_req[p]) @(negedge clk);
               delay = $urandom_range(5, 0);
               repeat (delay) @(negedge clk);
               ack = 1'b0;
            end
         end
      end
   end

   // hang guard
   always @(posedge clk) begin
      cycles++;
      if (limit > 0 && cycles > limit) begin
         $display("timeout: the run hung after %0d cycles", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   // fsm state trace
   always @(posedge clk) begin
      noc_pkg::fsm_state_t state_now;
      state_now = i_router_in_port.i_wormhole_fsm.state;
      if (rst_n && state_now != state_q) begin
         $display("[%0t] fsm state %s", $time, state_now.name());
      end
      state_q = state_now;
   end

   // one flit through the input four-phase handshake
   task automatic send_flit(input logic [15:0] f);
      in_flit = f;
      in_req  = 1'b1;
      @(negedge clk);
      while (!in_ack) @(negedge clk);
      in_req = 1'b0;
      @(negedge clk);
      while (in_ack) @(negedge clk);
   endtask

   // head flit then len body flits
   task automatic send_packet(input pkt_row_t row);
      logic [15:0] f;
      exp_route = row.port;
      f = {row.seed[15:12], row.len, row.dy, row.dx};
      send_flit(f);
      for (int k = 1; k <= int'(row.len); k++) begin
         send_flit(row.seed + 16'(k * 257));
      end
   endtask

   initial begin
      int total;
      void'($urandom(rand_seed));
      rst_n     = 1'b0;
      in_req    = 1'b0;
      in_flit   = '0;
      exp_route = '0;
      total     = 0;
      for (int i = 0; i < num_pkts; i++) begin
         total += int'(pkt_tab[i].len) + 1;
      end
      limit = 40 * total + 200;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int i = 0; i < num_pkts; i++) begin
         send_packet(pkt_tab[i]);
      end
      // drain the last packet
      while (pending != 0 || out_req != '0 || out_ack != '0) @(negedge clk);
      repeat (4) @(negedge clk);
      $display("errors: %0d value, %0d other, %0d flits not delivered",
               value_errors, other_errors, pending);
      if (value_errors == 0 && other_errors == 0 && pending == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule
